//--- loadStoreCore.f
verilog/cpuPkg.sv
verilog/phaseSequencer.sv
verilog/loadStoreGroupDecoder.sv
verilog/registerFile.sv
verilog/addrAlu.sv
verilog/dataMemory.sv
verilog/loadStoreCore.sv
verif/loadStoreCoreTb.sv

//--- verif/loadStoreGolden.txt
# M byte-address word | I instruction | G register value | C byte-address word
# all fields are hexadecimal, instruction bits are group incf ldsf modef x y
M 0000 0010
M 0010 1234
M 0012 abcd
M 007e 5a5a
I 4010
G 1 0010
I 4021
G 2 1234
G 1 0010
I 4420
C 0000 1234
G 0 0000
G 2 1234
I 5041
G 4 1234
G 1 0012
I 5051
G 5 abcd
G 1 0014
I 5451
I 5441
I 5411
C 0014 abcd
C 0016 1234
C 0018 0018
G 1 001a
I 6061
G 6 0018
G 1 0018
I 6451
C 0016 abcd
G 1 0016
I 6070
G 7 5a5a
G 0 fffe
I 6420
C 007c 1234
C fffc 1234
G 0 fffc
I 0021
I 4822
I 4521
I 8016
G 2 1234
G 1 0016
C 0016 abcd
I 5011
G 1 0018

//--- verif/loadStoreCoreTb.sv
// testbench for the load/store core that replays golden commands and checks registers and memory
`timescale 1ns/1ps
`default_nettype none

module loadStoreCoreTb;
	import cpuPkg::*;

	localparam GOLDEN = "verif/loadStoreGolden.txt";

	logic                  CLK;
	logic                  arstN;
	logic                  start;
	logic [DATA_W-1:0]     instr;
	logic                  busy;
	logic                  done;
	logic                  hostWe;
	logic [DATA_W-1:0]     hostAddr;
	logic [DATA_W-1:0]     hostWdata;
	logic [DATA_W-1:0]     hostRdata;
	logic [REG_ADDR_W-1:0] dbgAddr;
	logic [DATA_W-1:0]     dbgData;
	logic [31:0]           lfsr = 32'had8a_f586;  // idle gap generator state
	int                    lineCount = 0;        // set once the golden file has been sized

	loadStoreCore u_loadStoreCore (
		.CLK(CLK), .arstN(arstN), .start(start), .instr(instr), .busy(busy), .done(done),
		.hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata), .hostRdata(hostRdata),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;  // 20 ns period

	task automatic failValue(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "stopping on the first mismatch");
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	// Galois step, the bit shifted out is the random bit
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr   = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 32'h8020_0003;
		return outBit;
	endfunction

	task automatic idleGap();
		int n;
		n = lfsrBit();
		n = n * 2 + lfsrBit();  // two bits give 0 to 3 idle cycles
		repeat (n) @(negedge CLK);
	endtask

	task automatic hostWrite(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
		hostWe    = 1'b1;
		hostAddr  = addr;
		hostWdata = data;
		@(negedge CLK);
		hostWe = 1'b0;
	endtask

	// start to done must be four cycles, with busy high until the done cycle
	task automatic issue(input logic [DATA_W-1:0] word);
		int edges;
		start = 1'b1;
		instr = word;
		@(negedge CLK);
		edges = 1;
		instr = ~word;  // start stays high for one more edge while busy, the core must ignore it
		while (!done && edges < 8) begin
			assert (busy) else failValue($sformatf("busy low %0d cycles after start", edges));
			@(negedge CLK);
			start = 1'b0;
			edges++;
		end
		assert (edges == 5) else failValue($sformatf("done after %0d edges, expected 5", edges));
		assert (!busy) else failValue("busy still high in the done cycle");
		@(negedge CLK);
		assert (!done) else failValue("done longer than one cycle or a second done");
	endtask

	task automatic checkReg(input logic [REG_ADDR_W-1:0] idx, input logic [DATA_W-1:0] exp);
		dbgAddr = idx;
		#1;  // debug read is combinational
		assert (dbgData === exp)
			else failValue($sformatf("r%0d is %h, expected %h", idx, dbgData, exp));
		@(negedge CLK);
	endtask

	task automatic checkMem(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] exp);
		hostAddr = addr;
		#1;
		assert (hostRdata === exp)
			else failValue($sformatf("memory at %h is %h, expected %h", addr, hostRdata, exp));
		@(negedge CLK);
	endtask

	initial begin
		int                fd;
		int                code;
		int                lines;
		string             text;
		logic [7:0]        cmd;
		logic [DATA_W-1:0] f1;
		logic [DATA_W-1:0] f2;
		arstN     = 1'b0;
		start     = 1'b0;
		instr     = '0;
		hostWe    = 1'b0;
		hostAddr  = '0;
		hostWdata = '0;
		dbgAddr   = '0;
		lines     = 0;
		fd = $fopen(GOLDEN, "r");
		if (fd == 0)
			abortRun("could not open the golden file");
		while ($fgets(text, fd) != 0)
			lines++;
		$fclose(fd);
		lineCount = lines;  // arms the watchdog
		fd = $fopen(GOLDEN, "r");
		repeat (3) @(negedge CLK);
		arstN = 1'b1;
		while ($fscanf(fd, " %c", cmd) == 1) begin
			if (cmd == "#") begin
				code = $fgets(text, fd);  // comment line
			end else if (cmd == "I") begin
				code = $fscanf(fd, "%h", f1);
				if (code != 1)
					abortRun("golden file has an instruction line without a word");
				issue(f1);
				idleGap();
			end else begin
				code = $fscanf(fd, "%h %h", f1, f2);
				if (code != 2)
					abortRun("golden file has a line with missing fields");
				case (cmd)
					"M": begin
						hostWrite(f1, f2);
						idleGap();
					end
					"G": checkReg(f1[REG_ADDR_W-1:0], f2);
					"C": checkMem(f1, f2);
					default: abortRun("golden file has an unknown command letter");
				endcase
			end
		end
		$fclose(fd);
		$display("TESTS PASSED");
		$finish;
	end

	// each golden line costs at most about ten cycles
	initial begin
		wait (lineCount > 0);
		repeat (lineCount * 12 + 50) @(posedge CLK);
		$display("timeout, the core or the testbench stopped making progress");
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- verilog/loadStoreCore.sv
// load/store core top level joining the sequencer, decoder, register file, ALU and memory
`timescale 1ns/1ps
`default_nettype none

module loadStoreCore #(
	parameter int MEM_ADDR_W = 6
) (
	input  wire logic                          CLK,
	input  wire logic                          arstN,
	input  wire logic                          start,
	input  wire logic [cpuPkg::DATA_W-1:0]     instr,
	output logic                               busy,
	output logic                               done,
	input  wire logic                          hostWe,
	input  wire logic [cpuPkg::DATA_W-1:0]     hostAddr,
	input  wire logic [cpuPkg::DATA_W-1:0]     hostWdata,
	output logic      [cpuPkg::DATA_W-1:0]     hostRdata,
	input  wire logic [cpuPkg::REG_ADDR_W-1:0] dbgAddr,
	output logic      [cpuPkg::DATA_W-1:0]     dbgData
);
	import cpuPkg::*;

	logic [DATA_W-1:0]     instrReg;
	logic                  decode;
	logic                  execute;
	logic                  commit;
	logic                  regAClkEn;
	logic                  regBClkEn;
	logic                  regAWen;
	logic                  regBWen;
	logic                  memWen;
	aluOpT                 aluOp;
	aluASrcT               aluASrc;
	addrSrcT               addrSrc;
	dataSrcT               dataSrc;
	regSrcT                regASrc;
	regSrcT                regBSrc;
	logic [REG_ADDR_W-1:0] aIdx;
	logic [REG_ADDR_W-1:0] bIdx;
	logic [DATA_W-1:0]     rdA;
	logic [DATA_W-1:0]     rdB;
	logic [DATA_W-1:0]     aluA;
	logic [DATA_W-1:0]     aluResult;
	logic [DATA_W-1:0]     memAddr;
	logic [DATA_W-1:0]     memWdata;
	logic [DATA_W-1:0]     memRdata;
	logic [DATA_W-1:0]     wdataA;
	logic [DATA_W-1:0]     wdataB;

	// one write-source selector shared by both register ports
	function automatic logic [DATA_W-1:0] pickRegSrc(input regSrcT sel,
		input logic [DATA_W-1:0] din, input logic [DATA_W-1:0] alu,
		input logic [DATA_W-1:0] regB);
		case (sel)
			RSRC_DIN: return din;
			RSRC_ALU: return alu;
			RSRC_REG_B: return regB;
			default: return '0;
		endcase
	endfunction

	assign aIdx = instrReg[ARGA_LSB +: REG_ADDR_W];  // x in LD x,(y) and ST (y),x
	assign bIdx = instrReg[ARGB_LSB +: REG_ADDR_W];  // y, the index register

	// nothing in the load/store slice acts during fetch
	phaseSequencer u_phaseSequencer (
		.CLK(CLK), .arstN(arstN), .start(start), .instr(instr), .instrReg(instrReg),
		.fetch(), .decode(decode), .execute(execute), .commit(commit),
		.busy(busy), .done(done)
	);

	loadStoreGroupDecoder u_loadStoreGroupDecoder (
		.CLK(CLK), .arstN(arstN), .instrReg(instrReg),
		.decode(decode), .execute(execute), .commit(commit),
		.regAClkEn(regAClkEn), .regBClkEn(regBClkEn), .regAWen(regAWen), .regBWen(regBWen),
		.memWen(memWen), .aluOp(aluOp), .aluASrc(aluASrc), .addrSrc(addrSrc),
		.dataSrc(dataSrc), .regASrc(regASrc), .regBSrc(regBSrc)
	);

	registerFile u_registerFile (
		.CLK(CLK), .arstN(arstN), .aIdx(aIdx), .bIdx(bIdx),
		.regAClkEn(regAClkEn), .regBClkEn(regBClkEn), .regAWen(regAWen), .regBWen(regBWen),
		.wdataA(wdataA), .wdataB(wdataB), .rdA(rdA), .rdB(rdB),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	// ALU A operand, the B operand is always the index register
	always_comb begin
		case (aluASrc)
			ASRC_REG_A: aluA = rdA;
			ASRC_REG_B: aluA = rdB;
			ASRC_TWO:   aluA = DATA_W'(2);  // one word step in bytes
			default:    aluA = '0;
		endcase
	end

	addrAlu u_addrAlu (.aluOp(aluOp), .opA(aluA), .opB(rdB), .result(aluResult));

	assign memAddr  = (addrSrc == ADDR_ALU) ? aluResult : rdB;      // pre-decrement uses the ALU
	assign memWdata = (dataSrc == DOUT_REG_A) ? rdA : '0;
	assign wdataA   = pickRegSrc(regASrc, memRdata, aluResult, rdB);
	assign wdataB   = pickRegSrc(regBSrc, memRdata, aluResult, rdB);

	dataMemory #(.MEM_ADDR_W(MEM_ADDR_W)) u_dataMemory (
		.CLK(CLK), .arstN(arstN), .we(memWen), .addr(memAddr), .wdata(memWdata),
		.rdata(memRdata), .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata),
		.hostRdata(hostRdata)
	);

endmodule

`default_nettype wire

//--- verilog/dataMemory.sv
// word-wide data memory with a core port and a host port for loading and inspection
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
	parameter int MEM_ADDR_W = 6  // word address bits
) (
	input  wire logic                      CLK,
	input  wire logic                      arstN,
	input  wire logic                      we,
	input  wire logic [cpuPkg::DATA_W-1:0] addr,       // byte address, bit 0 ignored
	input  wire logic [cpuPkg::DATA_W-1:0] wdata,
	output logic      [cpuPkg::DATA_W-1:0] rdata,
	input  wire logic                      hostWe,
	input  wire logic [cpuPkg::DATA_W-1:0] hostAddr,   // byte address, same wrap as the core
	input  wire logic [cpuPkg::DATA_W-1:0] hostWdata,
	output logic      [cpuPkg::DATA_W-1:0] hostRdata
);
	import cpuPkg::*;

	localparam int DEPTH = 2 ** MEM_ADDR_W;

	logic [DATA_W-1:0]     mem [DEPTH];
	logic [MEM_ADDR_W-1:0] coreWord;
	logic [MEM_ADDR_W-1:0] hostWord;

	// upper address bits drop out so addresses wrap at the memory size
	assign coreWord = addr[MEM_ADDR_W:1];
	assign hostWord = hostAddr[MEM_ADDR_W:1];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else begin
			if (hostWe && !(we && hostWord == coreWord))
				mem[hostWord] <= hostWdata;
			if (we)
				mem[coreWord] <= wdata;  // core write beats the host on a collision
		end
	end

	assign rdata     = mem[coreWord];
	assign hostRdata = mem[hostWord];

endmodule

`default_nettype wire

//--- verilog/addrAlu.sv
// address ALU that adds, subtracts or forwards the index operand
`timescale 1ns/1ps
`default_nettype none

module addrAlu (
	input  wire cpuPkg::aluOpT             aluOp,
	input  wire logic [cpuPkg::DATA_W-1:0] opA,     // step size or second register
	input  wire logic [cpuPkg::DATA_W-1:0] opB,     // the index register
	output logic      [cpuPkg::DATA_W-1:0] result
);
	import cpuPkg::*;

	// all arithmetic wraps at the word width, carry is dropped
	always_comb begin
		case (aluOp)
			ALU_ADD:    result = opB + opA;
			ALU_SUB:    result = opB - opA;  // below zero wraps to the top of the range
			ALU_PASS_B: result = opB;
			default:    result = opB;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
// register file of sixteen words with read latches, two write ports and a debug read
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  wire logic                          CLK,
	input  wire logic                          arstN,
	input  wire logic [cpuPkg::REG_ADDR_W-1:0] aIdx,
	input  wire logic [cpuPkg::REG_ADDR_W-1:0] bIdx,
	input  wire logic                          regAClkEn,
	input  wire logic                          regBClkEn,
	input  wire logic                          regAWen,
	input  wire logic                          regBWen,
	input  wire logic [cpuPkg::DATA_W-1:0]     wdataA,
	input  wire logic [cpuPkg::DATA_W-1:0]     wdataB,
	output logic      [cpuPkg::DATA_W-1:0]     rdA,
	output logic      [cpuPkg::DATA_W-1:0]     rdB,
	input  wire logic [cpuPkg::REG_ADDR_W-1:0] dbgAddr,
	output logic      [cpuPkg::DATA_W-1:0]     dbgData
);
	import cpuPkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [DATA_W-1:0] regs [NUM_REGS];
	logic              writeA;
	logic              writeB;
	logic              aShadowed;  // port B hits the same register in this cycle

	assign writeA    = regAClkEn && regAWen;
	assign writeB    = regBClkEn && regBWen;
	assign aShadowed = writeB && (aIdx == bIdx);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (writeA && !aShadowed)
				regs[aIdx] <= wdataA;
			if (writeB)
				regs[bIdx] <= wdataB;  // B wins on a shared index
		end
	end

	// an enable on its own means read, the latch holds the operand for the next cycle
	always_ff @(posedge CLK) begin
		if (regAClkEn && !regAWen)
			rdA <= regs[aIdx];
		if (regBClkEn && !regBWen)
			rdB <= regs[bIdx];
	end

	assign dbgData = regs[dbgAddr];  // combinational peek for the testbench

endmodule

`default_nettype wire

//--- verilog/loadStoreGroupDecoder.sv
// load/store group decoder producing datapath selects and phase-registered register and memory enables
`timescale 1ns/1ps
`default_nettype none

module loadStoreGroupDecoder (
	input  wire logic                      CLK,
	input  wire logic                      arstN,
	input  wire logic [cpuPkg::DATA_W-1:0] instrReg,
	input  wire logic                      decode,
	input  wire logic                      execute,
	input  wire logic                      commit,
	output logic                           regAClkEn,
	output logic                           regBClkEn,
	output logic                           regAWen,
	output logic                           regBWen,
	output logic                           memWen,
	output cpuPkg::aluOpT                  aluOp,
	output cpuPkg::aluASrcT                aluASrc,
	output cpuPkg::addrSrcT                addrSrc,
	output cpuPkg::dataSrcT                dataSrc,
	output cpuPkg::regSrcT                 regASrc,
	output cpuPkg::regSrcT                 regBSrc
);
	import cpuPkg::*;

	logic [FIELD_W-1:0] group;
	logic [FIELD_W-1:0] mode;
	ldsOpT              ldsOp;
	incModeT            incMode;
	logic               isWordLdSt;  // the instruction belongs here and is not reserved

	// intents for the current instruction, turned into strobes per phase below
	logic readA;
	logic readB;
	logic writeA;
	logic writeB;
	logic writeMem;

	assign group   = instrReg[GPF_LSB +: FIELD_W];
	assign mode    = instrReg[MODEF_LSB +: FIELD_W];
	assign ldsOp   = ldsOpT'(instrReg[LDSF_LSB +: FIELD_W]);
	assign incMode = incModeT'(instrReg[INCF_LSB +: FIELD_W]);

	// anything outside word mode LD/ST falls through as a no-op
	assign isWordLdSt = (group == GRP_LDST) && (mode == MODE_WORD)
		&& (ldsOp == LDS_LD || ldsOp == LDS_ST) && (incMode != INC_RSV);

	always_comb begin
		readA    = 1'b0;
		readB    = 1'b0;
		writeA   = 1'b0;
		writeB   = 1'b0;
		writeMem = 1'b0;
		aluOp    = ALU_PASS_B;   // plain access just forwards the index
		aluASrc  = ASRC_REG_A;
		addrSrc  = ADDR_REG_B;
		dataSrc  = DOUT_ZERO;    // memory data bus is quiet unless storing
		regASrc  = RSRC_DIN;
		regBSrc  = RSRC_REG_B;

		if (isWordLdSt) begin
			case (ldsOp)
				LDS_LD: begin  // LD x,(y) needs y as address and writes x from memory
					readB   = 1'b1;
					writeA  = 1'b1;
					regASrc = RSRC_DIN;
				end
				LDS_ST: begin  // ST (y),x needs both registers
					readA    = 1'b1;
					readB    = 1'b1;
					writeMem = 1'b1;
					dataSrc  = DOUT_REG_A;
				end
				default: ;
			endcase

			case (incMode)
				INC_POST_INC: begin
					aluOp   = ALU_ADD;     // y + 2 goes back into y
					aluASrc = ASRC_TWO;
					addrSrc = ADDR_REG_B;  // old y is the address
					writeB  = 1'b1;
					regBSrc = RSRC_ALU;
				end
				INC_PRE_DEC: begin
					aluOp   = ALU_SUB;     // y - 2 is both the address and the new y
					aluASrc = ASRC_TWO;
					addrSrc = ADDR_ALU;
					writeB  = 1'b1;
					regBSrc = RSRC_ALU;
				end
				default: ;
			endcase
		end
	end

	// decode sets read latches, execute sets writes, commit clears everything
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regAClkEn <= 1'b0;
			regBClkEn <= 1'b0;
			regAWen   <= 1'b0;
			regBWen   <= 1'b0;
			memWen    <= 1'b0;
		end else if (decode) begin
			regAClkEn <= readA;  // captured into rdA at the end of execute
			regBClkEn <= readB;
		end else if (execute) begin
			regAClkEn <= writeA;
			regBClkEn <= writeB;
			regAWen   <= writeA;
			regBWen   <= writeB;
			memWen    <= writeMem;  // active through commit
		end else if (commit) begin
			regAClkEn <= 1'b0;
			regBClkEn <= 1'b0;
			regAWen   <= 1'b0;
			regBWen   <= 1'b0;
			memWen    <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/phaseSequencer.sv
// phase sequencer that latches an instruction on start and steps it through four phases
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
	input  wire logic                      CLK,
	input  wire logic                      arstN,
	input  wire logic                      start,     // one-cycle request, ignored while busy
	input  wire logic [cpuPkg::DATA_W-1:0] instr,
	output logic      [cpuPkg::DATA_W-1:0] instrReg,  // held for the whole instruction
	output logic                           fetch,
	output logic                           decode,
	output logic                           execute,
	output logic                           commit,
	output logic                           busy,
	output logic                           done       // single pulse after commit
);
	import cpuPkg::*;

	logic [3:0] phase;  // one-hot, bit 0 is fetch and bit 3 is commit
	logic       accept;

	assign accept = start && !busy;  // a start in the done cycle is taken

	// the one-hot vector walks left and falls off the top after commit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			phase <= '0;
			done  <= 1'b0;
		end else begin
			done <= phase[3];  // commit ending means the instruction retired
			if (accept)
				phase <= 4'b0001;
			else
				phase <= {phase[2:0], 1'b0};
		end
	end

	// instruction word only changes on an accepted start
	always_ff @(posedge CLK) begin
		if (accept)
			instrReg <= instr;
	end

	assign fetch   = phase[0];
	assign decode  = phase[1];
	assign execute = phase[2];
	assign commit  = phase[3];
	assign busy    = |phase;  // high from fetch through commit

endmodule

`default_nettype wire

//--- verilog/cpuPkg.sv
// CPU package with instruction field positions, group and operation codes and datapath selects
`default_nettype none

package cpuPkg;

	localparam int DATA_W     = 16;  // machine word width
	localparam int REG_ADDR_W = 4;   // register index width, 16 registers

	// instruction field positions, every control field is two bits wide
	localparam int FIELD_W   = 2;
	localparam int GPF_LSB   = 14;  // group field, bits 15 to 14
	localparam int INCF_LSB  = 12;  // increment/decrement field, bits 13 to 12
	localparam int LDSF_LSB  = 10;  // load/store operation, bits 11 to 10
	localparam int MODEF_LSB = 8;   // addressing mode, bits 9 to 8
	localparam int ARGA_LSB  = 4;   // register A index, bits 7 to 4
	localparam int ARGB_LSB  = 0;   // register B index, bits 3 to 0

	localparam logic [FIELD_W-1:0] GRP_LDST  = 2'b01;  // load/store group code
	localparam logic [FIELD_W-1:0] MODE_WORD = 2'b00;  // the only supported access width

	// load/store operation codes, the upper two are reserved
	typedef enum logic [1:0] {
		LDS_LD   = 2'b00,
		LDS_ST   = 2'b01,
		LDS_RSV2 = 2'b10,
		LDS_RSV3 = 2'b11
	} ldsOpT;

	// index register update applied to register B
	typedef enum logic [1:0] {
		INC_NONE     = 2'b00,
		INC_POST_INC = 2'b01,
		INC_PRE_DEC  = 2'b10,
		INC_RSV      = 2'b11
	} incModeT;

	typedef enum logic [1:0] {ALU_ADD = 2'd0, ALU_SUB = 2'd1, ALU_PASS_B = 2'd2} aluOpT;

	typedef enum logic [1:0] {ASRC_REG_A = 2'd0, ASRC_REG_B = 2'd1, ASRC_TWO = 2'd2} aluASrcT;

	typedef enum logic {ADDR_REG_B = 1'b0, ADDR_ALU = 1'b1} addrSrcT;

	typedef enum logic [1:0] {RSRC_DIN = 2'd0, RSRC_ALU = 2'd1, RSRC_REG_B = 2'd2} regSrcT;

	typedef enum logic {DOUT_REG_A = 1'b0, DOUT_ZERO = 1'b1} dataSrcT;

endpackage

`default_nettype wire
